// ==== filelist.f ====
hdl/cpu_ctrl_pkg.sv
hdl/decode_if.sv
hdl/insn_decode.sv
hdl/branch_eval.sv
hdl/step_sequencer.sv
hdl/cpu_control.sv
tests/cpu_control_props.sv
tests/cpu_control_tb.sv

// ==== hdl/branch_eval.sv ====
module branch_eval import cpu_ctrl_pkg::*; (
  input cond_t cond,
  input ccr_t ccr,
  output logic take
);

  logic sign_lt; // signed less than after a compare

  assign sign_lt = ccr.negative ^ ccr.overflow;

  always_comb begin
    case (cond)
      cond_always: take = 1'b1;
      cond_eq: take = ccr.zero;
      cond_ne: take = !ccr.zero;
      cond_gtu: take = !(ccr.zero | ccr.carry);
      cond_gt: take = !(ccr.zero | sign_lt);
      cond_ge: take = !sign_lt;
      cond_le: take = ccr.zero | sign_lt;
      cond_lt: take = sign_lt;
      cond_geu: take = !ccr.carry;
      cond_ltu: take = ccr.carry;
      cond_leu: take = ccr.carry | ccr.zero;
      cond_never: take = 1'b0;
      default: take = 1'b0;
    endcase
  end

endmodule

// ==== hdl/cpu_control.sv ====
module cpu_control import cpu_ctrl_pkg::*; (
  input logic clock,
  input logic reset_n,
  input logic [word_w-1:0] ir,
  input ccr_t ccr,
  input logic bus_wait,
  input logic [1:0] bus_align,
  output logic ir_write,
  output logic ccr_write,
  output logic reg_write,
  output logic bus_read,
  output logic bus_write,
  output logic addr_sel,
  output logic halted,
  output alu_func_t alu_func,
  output alu2_sel_t alu2_sel,
  output reg_sel_t reg_sel,
  output mar_sel_t mar_sel,
  output mdr_sel_t mdr_sel,
  output pc_sel_t pc_sel,
  output logic [reg_addr_w-1:0] reg_read_addr1,
  output logic [reg_addr_w-1:0] reg_read_addr2,
  output logic [reg_addr_w-1:0] reg_write_addr,
  output logic [3:0] byteenable
);

  logic take;

  decode_if dec ();

  insn_decode u_decode (
    .ir(ir),
    .dec(dec.decoder)
  );

  branch_eval u_branch (
    .cond(dec.cond),
    .ccr(ccr),
    .take(take)
  );

  assign reg_write_addr = dec.ra; // every write targets ra

  step_sequencer u_seq (
    .clock(clock),
    .reset_n(reset_n),
    .dec(dec.sequencer),
    .take(take),
    .bus_wait(bus_wait),
    .bus_align(bus_align),
    .ir_write(ir_write),
    .ccr_write(ccr_write),
    .reg_write(reg_write),
    .bus_read(bus_read),
    .bus_write(bus_write),
    .addr_sel(addr_sel),
    .halted(halted),
    .alu_func(alu_func),
    .alu2_sel(alu2_sel),
    .reg_sel(reg_sel),
    .mar_sel(mar_sel),
    .mdr_sel(mdr_sel),
    .pc_sel(pc_sel),
    .reg_read_addr1(reg_read_addr1),
    .reg_read_addr2(reg_read_addr2),
    .byteenable(byteenable)
  );

endmodule

// ==== hdl/cpu_ctrl_pkg.sv ====
package cpu_ctrl_pkg;

  localparam int word_w = 32;
  localparam int reg_addr_w = 5;
  localparam int op_w = 8;
  localparam int mode_w = 3;

  typedef enum logic [mode_w-1:0] {
    mode_reg = 3'h0,
    mode_regind = 3'h1,
    mode_imm = 3'h2,
    mode_dir = 3'h4
  } mode_t;

  // register and immediate mode opcodes
  typedef enum logic [op_w-1:0] {
    op_cmp = 8'h02,
    op_inc = 8'h03,
    op_dec = 8'h04,
    op_mov = 8'h07,
    op_com = 8'h08,
    op_neg = 8'h09,
    op_brn = 8'h0b, // last branch code
    op_ldiu = 8'h0d,
    op_extb = 8'h17,
    op_exth = 8'h18,
    op_nop = 8'h50
  } op_t;

  // register indirect opcodes, low nibble only
  typedef enum logic [3:0] {
    ind_st_word = 4'h0,
    ind_ld_word = 4'h1,
    ind_st_half = 4'h2,
    ind_ld_half = 4'h3,
    ind_st_byte = 4'h4,
    ind_ld_byte = 4'h5,
    ind_lda = 4'ha,
    ind_jmp = 4'hb
  } ind_op_t;

  typedef enum logic [4:0] {
    kind_nop, kind_cmp, kind_inc, kind_dec, kind_mov, kind_com, kind_neg,
    kind_extb, kind_exth, kind_alu3, kind_branch, kind_ldiu,
    kind_lda, kind_jmp, kind_load, kind_store,
    kind_illegal
  } insn_kind_t;

  typedef enum logic [1:0] {size_word, size_half, size_byte} access_size_t;

  typedef enum logic [3:0] {
    cond_always = 4'h0, cond_eq = 4'h1, cond_ne = 4'h2, cond_gtu = 4'h3,
    cond_gt = 4'h4, cond_ge = 4'h5, cond_le = 4'h6, cond_lt = 4'h7,
    cond_geu = 4'h8, cond_ltu = 4'h9, cond_leu = 4'ha, cond_never = 4'hb
  } cond_t;

  typedef enum logic [2:0] {
    alu_f0, alu_f1, alu_add, alu_sub, alu_f4, alu_f5, alu_f6, alu_f7
  } alu_func_t;

  typedef enum logic [2:0] {
    pc_hold = 3'h0, pc_incr = 3'h1, pc_from_mar = 3'h2,
    pc_rel_branch = 3'h3, pc_from_alu = 3'h4, pc_vector = 3'h5
  } pc_sel_t;

  typedef enum logic [3:0] {
    reg_alu = 4'h0, reg_mdr = 4'h1, reg_neg = 4'h2, reg_com = 4'h3,
    reg_mov = 4'h4, reg_imm16u = 4'h6, reg_extb = 4'h9, reg_exth = 4'ha
  } reg_sel_t;

  typedef enum logic [1:0] {alu2_reg = 2'h0, alu2_ind_offset = 2'h1, alu2_one = 2'h2} alu2_sel_t;
  typedef enum logic [1:0] {mar_hold = 2'h0, mar_bus = 2'h1, mar_alu = 2'h2} mar_sel_t;
  typedef enum logic [1:0] {mdr_hold = 2'h0, mdr_bus = 2'h1, mdr_reg_a = 2'h3} mdr_sel_t;

  typedef enum logic [1:0] {st_reset, st_fetch, st_execute, st_fault} state_t;
  typedef logic [2:0] step_t;

  typedef struct packed {
    logic carry;
    logic negative;
    logic overflow;
    logic zero;
  } ccr_t;

endpackage

// ==== hdl/decode_if.sv ====
interface decode_if import cpu_ctrl_pkg::*; ();

  insn_kind_t kind;
  logic [reg_addr_w-1:0] ra;
  logic [reg_addr_w-1:0] rb;
  logic [reg_addr_w-1:0] rc;
  alu_func_t alu_func; // raw op bits for the alu group
  access_size_t size;
  cond_t cond;

  modport decoder (
    output kind, ra, rb, rc, alu_func, size, cond
  );

  modport sequencer (
    input kind, ra, rb, rc, alu_func, size, cond
  );

endinterface

// ==== hdl/insn_decode.sv ====
module insn_decode import cpu_ctrl_pkg::*; (
  input logic [word_w-1:0] ir,
  decode_if.decoder dec
);

  logic [mode_w-1:0] mode;
  logic [op_w-1:0] op;
  logic [reg_addr_w-1:0] ra;
  logic [reg_addr_w-1:0] rb;
  logic [reg_addr_w-1:0] rc;

  // mode, op, ra, rb, rc packed from the top bit down
  assign {mode, op, ra, rb, rc} = ir[word_w-1 -: mode_w + op_w + 3 * reg_addr_w];

  assign dec.ra = ra;
  assign dec.rb = rb;
  assign dec.rc = rc;
  assign dec.alu_func = alu_func_t'(op[2:0]);
  assign dec.cond = cond_t'(op[3:0]);

  always_comb begin
    if (op[2])
      dec.size = size_byte;
    else if (op[1])
      dec.size = size_half;
    else
      dec.size = size_word;
  end

  always_comb begin
    dec.kind = kind_illegal;
    case (mode)
      mode_reg: begin
        if (op[7:4] == 4'h2) begin
          dec.kind = kind_alu3; // whole 0x2x row
        end else begin
          case (op)
            op_nop: dec.kind = kind_nop;
            op_cmp: dec.kind = kind_cmp;
            op_inc: dec.kind = kind_inc;
            op_dec: dec.kind = kind_dec;
            op_mov: dec.kind = kind_mov;
            op_com: dec.kind = kind_com;
            op_neg: dec.kind = kind_neg;
            op_extb: dec.kind = kind_extb;
            op_exth: dec.kind = kind_exth;
            default: dec.kind = kind_illegal;
          endcase
        end
      end
      mode_imm: begin
        if (op <= op_brn)
          dec.kind = kind_branch;
        else if (op == op_ldiu)
          dec.kind = kind_ldiu;
      end
      mode_regind: begin
        case (op[3:0]) // high nibble is don't care
          ind_st_word, ind_st_half, ind_st_byte: dec.kind = kind_store;
          ind_ld_word, ind_ld_half, ind_ld_byte: dec.kind = kind_load;
          ind_lda: dec.kind = kind_lda;
          ind_jmp: dec.kind = kind_jmp;
          default: dec.kind = kind_illegal;
        endcase
      end
      mode_dir: dec.kind = kind_illegal; // no argument fetch
      default: dec.kind = kind_illegal;
    endcase
  end

endmodule

// ==== hdl/step_sequencer.sv ====
module step_sequencer import cpu_ctrl_pkg::*; (
  input logic clock,
  input logic reset_n,
  decode_if.sequencer dec,
  input logic take,
  input logic bus_wait,
  input logic [1:0] bus_align,
  output logic ir_write,
  output logic ccr_write,
  output logic reg_write,
  output logic bus_read,
  output logic bus_write,
  output logic addr_sel,
  output logic halted,
  output alu_func_t alu_func,
  output alu2_sel_t alu2_sel,
  output reg_sel_t reg_sel,
  output mar_sel_t mar_sel,
  output mdr_sel_t mdr_sel,
  output pc_sel_t pc_sel,
  output logic [reg_addr_w-1:0] reg_read_addr1,
  output logic [reg_addr_w-1:0] reg_read_addr2,
  output logic [3:0] byteenable
);

  state_t state;
  state_t state_next;
  step_t step;
  step_t step_next;
  logic advance; // go to the next step
  logic done; // back to fetch
  logic [3:0] lane_en;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state <= st_reset;
      step <= '0;
    end else begin
      state <= state_next;
      step <= step_next;
    end
  end

  always_comb begin
    case (dec.size)
      size_half: lane_en = bus_align[1] ? 4'b0011 : 4'b1100;
      size_byte: lane_en = 4'b1000 >> bus_align; // one lane per offset
      default: lane_en = 4'b1111;
    endcase
  end

  always_comb begin
    state_next = state;
    step_next = step;
    advance = 1'b0;
    done = 1'b0;
    ir_write = 1'b0;
    ccr_write = 1'b0;
    reg_write = 1'b0;
    bus_read = 1'b0;
    bus_write = 1'b0;
    addr_sel = 1'b0; // address from pc
    halted = 1'b0;
    alu_func = alu_add;
    alu2_sel = alu2_reg;
    reg_sel = reg_alu;
    mar_sel = mar_hold;
    mdr_sel = mdr_hold;
    pc_sel = pc_hold;
    reg_read_addr1 = dec.ra;
    reg_read_addr2 = dec.rb;
    byteenable = 4'b1111;

    case (state)
      st_reset, st_fetch: begin
        case (step)
          3'd0: begin
            if (state == st_reset)
              pc_sel = pc_vector;
            bus_read = 1'b1;
            advance = !bus_wait; // hold request through wait states
          end
          3'd1: begin
            bus_read = 1'b1;
            if (state == st_reset)
              mar_sel = mar_bus; // vector address
            else
              ir_write = 1'b1;
            advance = 1'b1;
          end
          3'd2: begin
            if (state == st_reset) begin
              pc_sel = pc_from_mar;
              done = 1'b1;
            end else begin
              pc_sel = pc_incr;
              state_next = st_execute;
              step_next = '0;
            end
          end
          default: state_next = st_fault;
        endcase
      end
      st_execute: begin
        case (dec.kind)
          kind_nop: done = 1'b1;
          kind_cmp: begin
            alu_func = alu_sub;
            ccr_write = 1'b1;
            done = 1'b1;
          end
          kind_mov, kind_com, kind_neg, kind_extb, kind_exth, kind_ldiu: begin
            case (dec.kind)
              kind_mov: reg_sel = reg_mov;
              kind_com: reg_sel = reg_com;
              kind_neg: reg_sel = reg_neg;
              kind_extb: reg_sel = reg_extb;
              kind_exth: reg_sel = reg_exth;
              default: reg_sel = reg_imm16u;
            endcase
            reg_write = 1'b1;
            done = 1'b1;
          end
          kind_branch: begin
            if (take)
              pc_sel = pc_rel_branch;
            done = 1'b1;
          end
          kind_inc, kind_dec, kind_alu3, kind_lda, kind_jmp: begin
            case (dec.kind)
              kind_inc: alu2_sel = alu2_one;
              kind_dec: begin
                alu2_sel = alu2_one;
                alu_func = alu_sub;
              end
              kind_alu3: begin
                alu_func = dec.alu_func;
                reg_read_addr1 = dec.rb;
                reg_read_addr2 = dec.rc;
              end
              default: begin
                reg_read_addr1 = dec.rb; // base plus offset
                alu2_sel = alu2_ind_offset;
              end
            endcase
            if (step == 3'd0) begin
              advance = 1'b1;
            end else begin
              if (dec.kind == kind_jmp)
                pc_sel = pc_from_alu;
              else
                reg_write = 1'b1;
              done = 1'b1;
            end
          end
          kind_load, kind_store: begin
            addr_sel = 1'b1; // address from mar
            case (step)
              3'd0: begin
                reg_read_addr1 = dec.rb;
                alu2_sel = alu2_ind_offset;
                advance = 1'b1;
              end
              3'd1: begin
                mar_sel = mar_alu;
                advance = 1'b1;
              end
              3'd2: begin
                byteenable = lane_en;
                if (dec.kind == kind_load) begin
                  bus_read = 1'b1;
                  mdr_sel = mdr_bus;
                end else begin
                  bus_write = 1'b1;
                  mdr_sel = mdr_reg_a;
                end
                advance = !bus_wait;
              end
              default: begin
                if (dec.kind == kind_load) begin
                  reg_sel = reg_mdr;
                  reg_write = 1'b1;
                end
                done = 1'b1;
              end
            endcase
          end
          default: begin
            state_next = st_fault; // undefined encoding
            step_next = '0;
          end
        endcase
      end
      st_fault: halted = 1'b1; // stuck until reset
      default: state_next = st_fault;
    endcase

    if (done) begin
      state_next = st_fetch;
      step_next = '0;
    end else if (advance) begin
      step_next = step + 3'd1;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f filelist.f --top-module cpu_control_tb -o cpu_control_sim

output=$(./obj_dir/cpu_control_sim 2>&1 || true)
echo "$output"

if echo "$output" | grep -qx "sim passed"; then
  echo "result: PASS"
else
  echo "result: FAIL"
  exit 1
fi

// ==== tests/cpu_control_props.sv ====
module cpu_control_props (
  input logic clock,
  input logic reset_n,
  input logic bus_wait,
  input logic bus_read,
  input logic bus_write,
  input logic [3:0] byteenable,
  input logic ir_write,
  input logic ccr_write,
  input logic reg_write,
  input logic halted
);
  timeunit 1ns;
  timeprecision 100ps;

  one_request: assert property (@(posedge clock) disable iff (!reset_n)
    !(bus_read && bus_write)) else $error("bus_read and bus_write high together");

  // request held through wait states
  read_held: assert property (@(posedge clock) disable iff (!reset_n)
    bus_read && bus_wait |=> bus_read && $stable(byteenable))
    else $error("read request dropped during bus_wait");

  write_held: assert property (@(posedge clock) disable iff (!reset_n)
    bus_write && bus_wait |=> bus_write && $stable(byteenable))
    else $error("write request dropped during bus_wait");

  quiet_halt: assert property (@(posedge clock) disable iff (!reset_n)
    halted |-> !(bus_read || bus_write || reg_write || ccr_write || ir_write))
    else $error("request or write active while halted");

endmodule

bind cpu_control cpu_control_props u_props (
  .clock(clock),
  .reset_n(reset_n),
  .bus_wait(bus_wait),
  .bus_read(bus_read),
  .bus_write(bus_write),
  .byteenable(byteenable),
  .ir_write(ir_write),
  .ccr_write(ccr_write),
  .reg_write(reg_write),
  .halted(halted)
);

// ==== tests/cpu_control_tb.sv ====
module cpu_control_tb import cpu_ctrl_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [1:0] {cls_one, cls_two, cls_mem, cls_halt} cls_t;

  typedef struct packed {
    logic [word_w-1:0] ir;
    ccr_t ccr;
    logic [1:0] align;
    cls_t cls;
    logic wr; // reg_write in the last step
    logic ccrw;
    logic load;
    logic chk1; // compare read port 1
    logic chk2;
    reg_sel_t rsel;
    alu_func_t func;
    alu2_sel_t a2;
    pc_sel_t pc; // pc_sel in the last step
    logic [reg_addr_w-1:0] wa;
    logic [reg_addr_w-1:0] rd1;
    logic [reg_addr_w-1:0] rd2;
    logic [3:0] be;
  } entry_t;

  logic clock = 1'b0;
  logic reset_n = 1'b1;
  logic [word_w-1:0] ir;
  ccr_t ccr;
  logic bus_wait;
  logic [1:0] bus_align;
  logic ir_write;
  logic ccr_write;
  logic reg_write;
  logic bus_read;
  logic bus_write;
  logic addr_sel;
  logic halted;
  alu_func_t alu_func;
  alu2_sel_t alu2_sel;
  reg_sel_t reg_sel;
  mar_sel_t mar_sel;
  mdr_sel_t mdr_sel;
  pc_sel_t pc_sel;
  logic [reg_addr_w-1:0] reg_read_addr1;
  logic [reg_addr_w-1:0] reg_read_addr2;
  logic [reg_addr_w-1:0] reg_write_addr;
  logic [3:0] byteenable;

  entry_t stim[$];
  logic table_ready = 1'b0;
  int errors = 0;
  integer seed = 14;

  cpu_control DUT (.*);

  always #50 clock = ~clock;

  task automatic stop_on_error();
    errors++;
    $display("sim failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_mismatch(input string what, input string got, input string exp);
    $display("ERR %0t: %s is %s, expected %s", $time, what, got, exp);
    stop_on_error();
  endtask

  task automatic flag_is(input logic got, input logic exp, input string what);
    if (got !== exp)
      report_mismatch(what, $sformatf("%b", got), $sformatf("%b", exp));
  endtask

  task automatic pc_is(input pc_sel_t got, input pc_sel_t exp, input string what);
    if (got !== exp)
      report_mismatch(what, got.name(), exp.name());
  endtask

  task automatic reg_sel_is(input reg_sel_t got, input reg_sel_t exp, input string what);
    if (got !== exp)
      report_mismatch(what, got.name(), exp.name());
  endtask

  task automatic alu_is(input alu_func_t got, input alu_func_t exp, input string what);
    if (got !== exp)
      report_mismatch(what, got.name(), exp.name());
  endtask

  task automatic alu2_is(input alu2_sel_t got, input alu2_sel_t exp, input string what);
    if (got !== exp)
      report_mismatch(what, got.name(), exp.name());
  endtask

  task automatic mar_is(input mar_sel_t got, input mar_sel_t exp, input string what);
    if (got !== exp)
      report_mismatch(what, got.name(), exp.name());
  endtask

  task automatic mdr_is(input mdr_sel_t got, input mdr_sel_t exp, input string what);
    if (got !== exp)
      report_mismatch(what, got.name(), exp.name());
  endtask

  task automatic addr_is(input logic [reg_addr_w-1:0] got, input logic [reg_addr_w-1:0] exp,
                         input string what);
    if (got !== exp)
      report_mismatch(what, $sformatf("%0d", got), $sformatf("%0d", exp));
  endtask

  task automatic lanes_are(input logic [3:0] got, input logic [3:0] exp, input string what);
    if (got !== exp)
      report_mismatch(what, $sformatf("%b", got), $sformatf("%b", exp));
  endtask

  // flag rules of the branch conditions
  function automatic logic branch_taken(input cond_t c, input ccr_t f);
    logic lt;
    lt = f.negative ^ f.overflow; // signed less than
    case (c)
      cond_always: return 1'b1;
      cond_eq: return f.zero;
      cond_ne: return !f.zero;
      cond_gtu: return !f.carry && !f.zero;
      cond_gt: return !lt && !f.zero;
      cond_ge: return !lt;
      cond_le: return lt || f.zero;
      cond_lt: return lt;
      cond_geu: return !f.carry;
      cond_ltu: return f.carry;
      cond_leu: return f.carry || f.zero;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [3:0] lane_mask(input access_size_t s, input logic [1:0] a);
    case (s)
      size_half: return a[1] ? 4'b0011 : 4'b1100;
      size_byte: begin
        case (a)
          2'd0: return 4'b1000; // lane 3 holds the lowest address
          2'd1: return 4'b0100;
          2'd2: return 4'b0010;
          default: return 4'b0001;
        endcase
      end
      default: return 4'b1111;
    endcase
  endfunction

  function automatic entry_t new_entry(input mode_t m, input logic [op_w-1:0] op,
                                       input cls_t c);
    entry_t e;
    int k;
    logic [reg_addr_w-1:0] ra;
    logic [reg_addr_w-1:0] rb;
    logic [reg_addr_w-1:0] rc;
    k = stim.size();
    ra = reg_addr_w'(k);
    rb = reg_addr_w'(k + 11);
    rc = reg_addr_w'(k + 22);
    e = '0;
    e.ir = {m, op, ra, rb, rc, 6'd0}; // fields packed from the top bit down
    e.cls = c;
    e.func = alu_add;
    e.a2 = alu2_reg;
    e.rsel = reg_alu;
    e.pc = pc_hold;
    e.wa = ra;
    e.rd1 = rb;
    e.rd2 = rc;
    e.be = 4'b1111;
    return e;
  endfunction

  task automatic push_reg_write(input mode_t m, input logic [op_w-1:0] op, input reg_sel_t rs);
    entry_t e;
    e = new_entry(m, op, cls_one);
    e.wr = 1'b1;
    e.rsel = rs;
    stim.push_back(e);
  endtask

  task automatic build_table();
    entry_t e;
    int c;
    int f;
    int s;
    int ld;
    int a;
    push_reg_write(mode_reg, op_mov, reg_mov);
    push_reg_write(mode_reg, op_com, reg_com);
    push_reg_write(mode_reg, op_neg, reg_neg);
    push_reg_write(mode_reg, op_extb, reg_extb);
    push_reg_write(mode_reg, op_exth, reg_exth);
    push_reg_write(mode_imm, op_ldiu, reg_imm16u);
    stim.push_back(new_entry(mode_reg, op_nop, cls_one));
    e = new_entry(mode_reg, op_cmp, cls_one);
    e.ccrw = 1'b1;
    e.func = alu_sub;
    stim.push_back(e);
    e = new_entry(mode_reg, op_inc, cls_two);
    e.wr = 1'b1;
    e.a2 = alu2_one;
    stim.push_back(e);
    e = new_entry(mode_reg, op_dec, cls_two);
    e.wr = 1'b1;
    e.a2 = alu2_one;
    e.func = alu_sub;
    stim.push_back(e);
    for (f = 0; f < 8; f++) begin
      e = new_entry(mode_reg, op_w'('h20 + f), cls_two);
      e.wr = 1'b1;
      e.func = alu_func_t'(f[2:0]); // function code from op bits 2:0
      e.chk1 = 1'b1;
      e.chk2 = 1'b1;
      stim.push_back(e);
    end
    e = new_entry(mode_regind, 8'h7a, cls_two); // lda with a junk high nibble
    e.wr = 1'b1;
    e.a2 = alu2_ind_offset;
    e.chk1 = 1'b1;
    stim.push_back(e);
    e = new_entry(mode_regind, 8'hcb, cls_two); // jmp
    e.a2 = alu2_ind_offset;
    e.pc = pc_from_alu;
    e.chk1 = 1'b1;
    stim.push_back(e);
    for (c = 0; c < 12; c++) begin
      for (f = 0; f < 16; f++) begin
        e = new_entry(mode_imm, op_w'(c), cls_one);
        e.ccr = ccr_t'(f[3:0]);
        if (branch_taken(cond_t'(c[3:0]), e.ccr))
          e.pc = pc_rel_branch;
        stim.push_back(e);
      end
    end
    for (s = 0; s < 3; s++) begin
      for (ld = 0; ld < 2; ld++) begin
        for (a = 0; a < 4; a++) begin
          e = new_entry(mode_regind, {4'(a), 4'(2 * s + ld)}, cls_mem);
          e.align = a[1:0];
          e.load = ld[0];
          e.wr = ld[0];
          e.rsel = reg_mdr;
          e.chk1 = 1'b1;
          e.be = lane_mask(access_size_t'(s[1:0]), a[1:0]);
          stim.push_back(e);
        end
      end
    end
    stim.push_back(new_entry(mode_dir, 8'h01, cls_halt)); // direct mode is gone
    stim.push_back(new_entry(mode_reg, 8'h33, cls_halt));
  endtask

  // drive at the falling edge and check 10 ns later in each cycle
  task automatic bus_handshake(input logic load, input logic addr, input logic [3:0] be,
                               input pc_sel_t pc, input mdr_sel_t mdr);
    int r;
    int waits;
    int i;
    r = $random(seed);
    waits = r & 3;
    for (i = 0; i <= waits; i++) begin
      bus_wait = (i < waits);
      #10;
      flag_is(bus_read, load, "bus_read in bus step");
      flag_is(bus_write, !load, "bus_write in bus step");
      flag_is(addr_sel, addr, "addr_sel in bus step");
      lanes_are(byteenable, be, "byteenable in bus step");
      pc_is(pc_sel, pc, "pc_sel in bus step");
      mdr_is(mdr_sel, mdr, "mdr_sel in bus step");
      @(negedge clock);
    end
  endtask

  task automatic reset_and_vector();
    reset_n = 1'b0;
    bus_wait = 1'b0;
    repeat (4) @(negedge clock);
    #10;
    flag_is(bus_read, 1'b1, "bus_read in reset");
    flag_is(ir_write | reg_write | ccr_write | bus_write | halted, 1'b0, "strobes in reset");
    @(negedge clock);
    reset_n = 1'b1;
    bus_handshake(1'b1, 1'b0, 4'b1111, pc_vector, mdr_hold);
    #10;
    mar_is(mar_sel, mar_bus, "mar_sel after vector read");
    flag_is(bus_read, 1'b1, "bus_read after vector read");
    @(negedge clock);
    #10;
    pc_is(pc_sel, pc_from_mar, "pc_sel at end of vector load");
    flag_is(bus_read, 1'b0, "bus_read at end of vector load");
    @(negedge clock);
  endtask

  task automatic operands_ok(input entry_t e);
    alu_is(alu_func, e.func, "alu_func");
    alu2_is(alu2_sel, e.a2, "alu2_sel");
    if (e.chk1)
      addr_is(reg_read_addr1, e.rd1, "reg_read_addr1");
    if (e.chk2)
      addr_is(reg_read_addr2, e.rd2, "reg_read_addr2");
  endtask

  task automatic last_step_checks(input entry_t e);
    flag_is(reg_write, e.wr, "reg_write in last step");
    flag_is(ccr_write, e.ccrw, "ccr_write in last step");
    flag_is(bus_read | bus_write, 1'b0, "bus request in last step");
    pc_is(pc_sel, e.pc, "pc_sel in last step");
    if (e.ccrw)
      alu_is(alu_func, e.func, "alu_func of compare");
    if (e.wr) begin
      reg_sel_is(reg_sel, e.rsel, "reg_sel");
      addr_is(reg_write_addr, e.wa, "reg_write_addr");
    end
  endtask

  task automatic run_insn(input entry_t e);
    int i;
    bus_handshake(1'b1, 1'b0, 4'b1111, pc_hold, mdr_hold);
    ir = e.ir; // word arrives with ir_write
    ccr = e.ccr;
    bus_align = e.align;
    #10;
    flag_is(ir_write, 1'b1, "ir_write after fetch handshake");
    flag_is(bus_read, 1'b1, "bus_read while ir is written");
    @(negedge clock);
    #10;
    pc_is(pc_sel, pc_incr, "pc_sel at end of fetch");
    flag_is(ir_write, 1'b0, "ir_write at end of fetch");
    @(negedge clock);
    case (e.cls)
      cls_one: begin
        #10;
        last_step_checks(e);
        @(negedge clock);
      end
      cls_two: begin
        #10;
        operands_ok(e);
        flag_is(reg_write, 1'b0, "reg_write in first step");
        pc_is(pc_sel, pc_hold, "pc_sel in first step");
        @(negedge clock);
        #10;
        operands_ok(e);
        last_step_checks(e);
        @(negedge clock);
      end
      cls_mem: begin
        #10;
        alu2_is(alu2_sel, alu2_ind_offset, "alu2_sel of address step");
        addr_is(reg_read_addr1, e.rd1, "base register of address step");
        lanes_are(byteenable, 4'b1111, "byteenable outside bus step");
        @(negedge clock);
        #10;
        mar_is(mar_sel, mar_alu, "mar_sel before bus step");
        @(negedge clock);
        bus_handshake(e.load, 1'b1, e.be, pc_hold, e.load ? mdr_bus : mdr_reg_a);
        #10;
        last_step_checks(e);
        @(negedge clock);
      end
      default: begin
        #10;
        flag_is(halted, 1'b0, "halted in execute step");
        flag_is(reg_write, 1'b0, "reg_write for undefined encoding");
        @(negedge clock);
        for (i = 0; i < 10; i++) begin
          #10;
          flag_is(halted, 1'b1, "halted after undefined encoding");
          flag_is(bus_read | bus_write, 1'b0, "bus request while halted");
          @(negedge clock);
        end
        reset_and_vector();
      end
    endcase
  endtask

  initial begin
    ir = '0;
    ccr = '0;
    bus_wait = 1'b0;
    bus_align = 2'd0;
    build_table();
    table_ready = 1'b1;
    reset_and_vector();
    foreach (stim[i])
      run_insn(stim[i]);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // worst case per entry plus reset and vector load
  initial begin
    wait (table_ready);
    #((stim.size() * (12 + 4 * 3) + 5 + 6) * 100);
    $display("watchdog timeout: the DUT hung before the table was done");
    stop_on_error();
  end

endmodule
